// ==== filelist.f ====
+incdir+src
src/synth_pkg.sv
src/slot_sequencer.sv
src/phase_osc.sv
src/voice_params.sv
src/vol_mixer.sv
src/synth_core.sv
sim/synth_chk.sv
sim/synth_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= synth_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= *** TEST FAILED ***
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -qF "$(PASS_MSG)" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/synth_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "synth_params.svh"

module synth_tb;

    localparam int NOSC = synth_pkg::NUM_OSC;
    localparam int CLK_NS = 8;
    localparam int WATCHDOG_NS = 200 * `SYN_FRAME * CLK_NS;
    localparam real PI = 3.14159265358979;

    logic                            sCLK_XVXENVS;
    logic                            reset;
    logic                            cfg_we;
    synth_pkg::cfg_kind_e            cfg_kind;
    synth_pkg::slot_t                cfg_addr;
    logic [31:0]                     cfg_data;
    synth_pkg::level_t               master_vol;
    logic [`SYN_VOICES-1:0]          key_gate;
    logic signed [`SYN_AUD_BITS-1:0] lsound_out;
    logic signed [`SYN_AUD_BITS-1:0] rsound_out;
    logic                            sample_valid;

    // Model of the configured state and the running phases.
    synth_pkg::phase_t      m_inc [NOSC];
    synth_pkg::phase_t      m_phase [NOSC];
    synth_pkg::level_t      m_olvl [NOSC];
    synth_pkg::pan_t        m_pan [NOSC];
    synth_pkg::level_t      m_vlvl [`SYN_VOICES];
    logic [`SYN_VOICES-1:0] m_gate;
    synth_pkg::level_t      m_master;

    bit armed;
    bit skip;
    int checked;
    int cyc;
    int last_valid;
    int seed;

    synth_core dut0 (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .reset        (reset),
        .cfg_we       (cfg_we),
        .cfg_kind     (cfg_kind),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .master_vol   (master_vol),
        .key_gate     (key_gate),
        .lsound_out   (lsound_out),
        .rsound_out   (rsound_out),
        .sample_valid (sample_valid)
    );

    always #(CLK_NS / 2) sCLK_XVXENVS = ~sCLK_XVXENVS;

    // Clock edges since reset was released.
    always @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            cyc <= 0;
        end else begin
            cyc <= cyc + 1;
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_sample(input string name,
                                input logic signed [`SYN_AUD_BITS-1:0] got,
                                input logic signed [`SYN_AUD_BITS-1:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERROR t=%0t %s: got %0d expected %0d",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_interval(input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("ERROR t=%0t sample_valid interval: got %0d expected %0d",
                                $time, got, exp));
        end
    endtask

    // Sine rule, rounded to nearest over the full period.
    function automatic int sine_ref(input int k);
        return int'(32767.0 * $sin(2.0 * PI * k / real'(1 << `SYN_LUT_BITS)));
    endfunction

    function automatic logic signed [`SYN_AUD_BITS-1:0] ref_sample(input bit right);
        longint sum;
        longint term;
        int     k;
        int     v;
        int     p;
        sum = 0;
        for (int i = 0; i < NOSC; i++) begin
            v = i / `SYN_V_OSC;
            k = m_phase[i][31 -: `SYN_LUT_BITS];
            p = right ? 127 - int'(m_pan[i]) : int'(m_pan[i]);
            if (m_gate[v]) begin
                term = longint'(sine_ref(k)) * longint'(m_vlvl[v])
                       * longint'(m_olvl[i]) * longint'(p);
                sum += term;
            end
        end
        sum = (sum * longint'(m_master)) >>> `SYN_OUT_SHIFT;
        return sum[`SYN_AUD_BITS-1:0];
    endfunction

    task automatic advance_phases();
        for (int i = 0; i < NOSC; i++) begin
            m_phase[i] = m_phase[i] + m_inc[i];
        end
    endtask

    always @(negedge sCLK_XVXENVS) begin
        if (!reset && sample_valid) begin
            check_interval(cyc - last_valid, (last_valid == 0) ? `SYN_FRAME + 3 : `SYN_FRAME);
            last_valid = cyc;
            if (armed && skip) begin
                skip = 1'b0;
            end else if (armed) begin
                check_sample("lsound_out", lsound_out, ref_sample(1'b0));
                check_sample("rsound_out", rsound_out, ref_sample(1'b1));
                advance_phases();
                checked++;
            end
        end
    end

    task automatic write_cfg(input synth_pkg::cfg_kind_e kind, input int addr,
                             input logic [31:0] data);
        cfg_we   = 1'b1;
        cfg_kind = kind;
        cfg_addr = synth_pkg::slot_t'(addr);
        cfg_data = data;
        @(posedge sCLK_XVXENVS);
        #1;
        cfg_we = 1'b0;
    endtask

    task automatic wait_valid();
        do begin
            @(posedge sCLK_XVXENVS);
            #1;
        end while (!sample_valid);
    endtask

    task automatic run_frames(input int n);
        int target;
        target = checked + n;
        while (checked < target) begin
            @(posedge sCLK_XVXENVS);
            #1;
        end
    endtask

    task automatic clear_model();
        for (int i = 0; i < NOSC; i++) begin
            m_inc[i]   = '0;
            m_phase[i] = '0;
            m_olvl[i]  = '0;
            m_pan[i]   = '0;
        end
        for (int v = 0; v < `SYN_VOICES; v++) begin
            m_vlvl[v] = '0;
        end
        m_gate   = '0;
        m_master = '0;
    endtask

    task automatic randomize_model();
        for (int i = 0; i < NOSC; i++) begin
            m_inc[i]  = $random(seed);
            m_olvl[i] = synth_pkg::level_t'($random(seed));
            m_pan[i]  = synth_pkg::pan_t'($random(seed));
        end
        for (int v = 0; v < `SYN_VOICES; v++) begin
            m_vlvl[v] = synth_pkg::level_t'($random(seed));
        end
        m_gate   = '1;
        m_master = synth_pkg::level_t'($random(seed));
    endtask

    // Levels first, then all increments in one aligned run so every
    // phase restarts at zero for the next full frame.
    task automatic commit();
        armed      = 1'b0;
        key_gate   = m_gate;
        master_vol = m_master;
        for (int v = 0; v < `SYN_VOICES; v++) begin
            write_cfg(synth_pkg::CFG_VOICE_LVL, v, 32'(m_vlvl[v]));
        end
        for (int i = 0; i < NOSC; i++) begin
            write_cfg(synth_pkg::CFG_OSC_LVL, i, 32'(m_olvl[i]));
            write_cfg(synth_pkg::CFG_PAN, i, 32'(m_pan[i]));
        end
        wait_valid();
        @(posedge sCLK_XVXENVS);
        #1;
        for (int i = 0; i < NOSC; i++) begin
            write_cfg(synth_pkg::CFG_INC, i, m_inc[i]);
            m_phase[i] = '0;
        end
        skip  = 1'b1;
        armed = 1'b1;
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        sCLK_XVXENVS = 1'b0;
        reset        = 1'b1;
        cfg_we       = 1'b0;
        cfg_kind     = synth_pkg::CFG_INC;
        cfg_addr     = '0;
        cfg_data     = '0;
        master_vol   = '0;
        key_gate     = '0;
        seed         = 32'h7c24_5351;
        clear_model();
        armed   = 1'b1;
        skip    = 1'b0;
        checked = 0;
        repeat (8) @(posedge sCLK_XVXENVS);
        #1;
        reset = 1'b0;
        run_frames(4);
        // Single oscillator, frozen then running.
        m_gate    = '1;
        m_master  = 8'sd127;
        m_vlvl[0] = 8'sd127;
        m_olvl[0] = 8'sd127;
        m_pan[0]  = 7'd64;
        commit();
        run_frames(4);
        m_inc[0] = 32'h0123_4567;
        commit();
        run_frames(8);
        m_pan[0] = 7'd0;
        commit();
        run_frames(4);
        m_pan[0] = 7'd127;
        commit();
        run_frames(4);
        m_pan[0] = 7'd37;
        commit();
        run_frames(4);
        // Gate off one voice of a full random setup.
        randomize_model();
        commit();
        run_frames(4);
        m_gate[2] = 1'b0;
        commit();
        run_frames(4);
        randomize_model();
        commit();
        run_frames(50);
        m_master = -m_master;
        commit();
        run_frames(50);
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/synth_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "synth_params.svh"

module synth_chk (
    input logic                      sCLK_XVXENVS,
    input logic                      reset,
    input logic                      sample_valid,
    input logic [`SYN_AUD_BITS-1:0]  lsound_out,
    input logic [`SYN_AUD_BITS-1:0]  rsound_out
);

    int unsigned gap;
    logic        seen;

    // Cycles since the last sample_valid.
    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            gap  <= 0;
            seen <= 1'b0;
        end else if (sample_valid) begin
            gap  <= 1;
            seen <= 1'b1;
        end else begin
            gap <= gap + 1;
        end
    end

    valid_low_in_reset: assert property (
        @(posedge sCLK_XVXENVS) reset |=> !sample_valid
    ) else $error("sample_valid high during reset");

    frame_spacing: assert property (
        @(posedge sCLK_XVXENVS) disable iff (reset)
        (sample_valid && seen) |-> (gap == `SYN_FRAME)
    ) else $error("sample_valid spacing differs from one frame");

    outputs_known: assert property (
        @(posedge sCLK_XVXENVS) disable iff (reset)
        !$isunknown({sample_valid, lsound_out, rsound_out})
    ) else $error("unknown value on an output");

endmodule

bind synth_core synth_chk chk0 (
    .sCLK_XVXENVS (sCLK_XVXENVS),
    .reset        (reset),
    .sample_valid (sample_valid),
    .lsound_out   (lsound_out),
    .rsound_out   (rsound_out)
);

`default_nettype wire

// ==== src/synth_core.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "synth_params.svh"

module synth_core (
    input  logic                             sCLK_XVXENVS,
    input  logic                             reset,
    input  logic                             cfg_we,
    input  synth_pkg::cfg_kind_e             cfg_kind,
    input  synth_pkg::slot_t                 cfg_addr,
    input  logic [31:0]                      cfg_data,
    input  synth_pkg::level_t                master_vol,
    input  logic [`SYN_VOICES-1:0]           key_gate,
    output logic signed [`SYN_AUD_BITS-1:0]  lsound_out,
    output logic signed [`SYN_AUD_BITS-1:0]  rsound_out,
    output logic                             sample_valid
);

    synth_pkg::slot_t   slot;
    synth_pkg::slot_t   slot_d2;
    logic               osc_stb;
    logic               voice_end;
    logic               frame_end;
    synth_pkg::sample_t sine_out;
    synth_pkg::level_t  voice_lvl;
    synth_pkg::level_t  osc_lvl;
    synth_pkg::pan_t    osc_pan;

    slot_sequencer u_seq (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .reset        (reset),
        .slot         (slot),
        .slot_d2      (slot_d2),
        .osc_stb      (osc_stb),
        .voice_end    (voice_end),
        .frame_end    (frame_end)
    );

    phase_osc u_osc (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .reset        (reset),
        .slot         (slot),
        .cfg_we       (cfg_we),
        .cfg_kind     (cfg_kind),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .sine_out     (sine_out)
    );

    voice_params u_par (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .reset        (reset),
        .cfg_we       (cfg_we),
        .cfg_kind     (cfg_kind),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .key_gate     (key_gate),
        .slot_d2      (slot_d2),
        .voice_lvl    (voice_lvl),
        .osc_lvl      (osc_lvl),
        .osc_pan      (osc_pan)
    );

    vol_mixer u_mix (
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .reset        (reset),
        .osc_stb      (osc_stb),
        .voice_end    (voice_end),
        .frame_end    (frame_end),
        .sine_out     (sine_out),
        .voice_lvl    (voice_lvl),
        .osc_lvl      (osc_lvl),
        .osc_pan      (osc_pan),
        .master_vol   (master_vol),
        .lsound_out   (lsound_out),
        .rsound_out   (rsound_out),
        .sample_valid (sample_valid)
    );

endmodule

`default_nettype wire

// ==== src/vol_mixer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "synth_params.svh"

module vol_mixer (
    input  logic                             sCLK_XVXENVS,
    input  logic                             reset,
    input  logic                             osc_stb,
    input  logic                             voice_end,
    input  logic                             frame_end,
    input  synth_pkg::sample_t               sine_out,
    input  synth_pkg::level_t                voice_lvl,
    input  synth_pkg::level_t                osc_lvl,
    input  synth_pkg::pan_t                  osc_pan,
    input  synth_pkg::level_t                master_vol,
    output logic signed [`SYN_AUD_BITS-1:0]  lsound_out,
    output logic signed [`SYN_AUD_BITS-1:0]  rsound_out,
    output logic                             sample_valid
);

    localparam int AUD = `SYN_AUD_BITS;
    localparam int SHIFT = `SYN_OUT_SHIFT;

    logic signed [24:0] p1;
    logic signed [32:0] p2;
    synth_pkg::level_t  ol_a;
    synth_pkg::pan_t    pan_a;
    synth_pkg::pan_t    pan_b;
    synth_pkg::acc_t    term_l;
    synth_pkg::acc_t    term_r;

    // Strobes follow the three multiply stages.
    logic [2:0] stb_sr;
    logic [2:0] ve_sr;
    logic [2:0] fe_sr;

    synth_pkg::acc_t voice_l;
    synth_pkg::acc_t voice_r;
    synth_pkg::acc_t frame_l;
    synth_pkg::acc_t frame_r;
    synth_pkg::acc_t full_l;
    synth_pkg::acc_t full_r;
    synth_pkg::acc_t scaled_l;
    synth_pkg::acc_t scaled_r;

    // Multiply chain: voice level, then oscillator level, then pan split.
    always_ff @(posedge sCLK_XVXENVS) begin
        p1     <= 25'(sine_out) * 25'(voice_lvl);
        ol_a   <= osc_lvl;
        pan_a  <= osc_pan;
        p2     <= 33'(p1) * 33'(ol_a);
        pan_b  <= pan_a;
        term_l <= synth_pkg::acc_t'(p2) * synth_pkg::acc_t'($signed({1'b0, pan_b}));
        term_r <= synth_pkg::acc_t'(p2)
                  * synth_pkg::acc_t'($signed({1'b0, synth_pkg::pan_t'(7'd127 - pan_b)}));
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            stb_sr <= '0;
            ve_sr  <= '0;
            fe_sr  <= '0;
        end else begin
            stb_sr <= {stb_sr[1:0], osc_stb};
            ve_sr  <= {ve_sr[1:0], voice_end};
            fe_sr  <= {fe_sr[1:0], frame_end};
        end
    end

    // Per voice sums; the next voice's first term loads on the boundary.
    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            voice_l <= '0;
            voice_r <= '0;
        end else if (ve_sr[2]) begin
            voice_l <= stb_sr[2] ? term_l : '0;
            voice_r <= stb_sr[2] ? term_r : '0;
        end else if (stb_sr[2]) begin
            voice_l <= voice_l + term_l;
            voice_r <= voice_r + term_r;
        end
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            frame_l <= '0;
            frame_r <= '0;
        end else if (fe_sr[2]) begin
            frame_l <= '0;
            frame_r <= '0;
        end else if (ve_sr[2]) begin
            frame_l <= frame_l + voice_l;
            frame_r <= frame_r + voice_r;
        end
    end

    assign full_l = frame_l * synth_pkg::acc_t'(master_vol);
    assign full_r = frame_r * synth_pkg::acc_t'(master_vol);
    assign scaled_l = full_l >>> SHIFT;
    assign scaled_r = full_r >>> SHIFT;

    // Output registers, updated once per frame.
    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            lsound_out   <= '0;
            rsound_out   <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= fe_sr[2];
            if (fe_sr[2]) begin
                lsound_out <= scaled_l[AUD-1:0];
                rsound_out <= scaled_r[AUD-1:0];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/voice_params.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "synth_params.svh"

module voice_params (
    input  logic                    sCLK_XVXENVS,
    input  logic                    reset,
    input  logic                    cfg_we,
    input  synth_pkg::cfg_kind_e    cfg_kind,
    input  synth_pkg::slot_t        cfg_addr,
    input  logic [31:0]             cfg_data,
    input  logic [`SYN_VOICES-1:0]  key_gate,
    input  synth_pkg::slot_t        slot_d2,
    output synth_pkg::level_t       voice_lvl,
    output synth_pkg::level_t       osc_lvl,
    output synth_pkg::pan_t         osc_pan
);

    localparam int OIDX = synth_pkg::OIDX_BITS;
    localparam int VBITS = synth_pkg::VOICE_BITS;

    synth_pkg::level_t voice_bank [`SYN_VOICES];
    synth_pkg::level_t lvl_bank [synth_pkg::NUM_OSC];
    synth_pkg::pan_t   pan_bank [synth_pkg::NUM_OSC];

    logic             osc_addr_ok;
    logic             voice_addr_ok;
    logic [VBITS-1:0] v_idx;

    assign osc_addr_ok = (cfg_addr < synth_pkg::slot_t'(synth_pkg::NUM_OSC));
    assign voice_addr_ok = (cfg_addr < synth_pkg::slot_t'(`SYN_VOICES));

    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            for (int i = 0; i < `SYN_VOICES; i++) begin
                voice_bank[i] <= '0;
            end
            for (int i = 0; i < synth_pkg::NUM_OSC; i++) begin
                lvl_bank[i] <= '0;
                pan_bank[i] <= '0;
            end
        end else if (cfg_we) begin
            case (cfg_kind)
                synth_pkg::CFG_OSC_LVL:
                    if (osc_addr_ok) lvl_bank[cfg_addr[OIDX-1:0]] <= cfg_data[7:0];
                synth_pkg::CFG_PAN:
                    if (osc_addr_ok) pan_bank[cfg_addr[OIDX-1:0]] <= cfg_data[6:0];
                synth_pkg::CFG_VOICE_LVL:
                    if (voice_addr_ok) voice_bank[cfg_addr[VBITS-1:0]] <= cfg_data[7:0];
                default: ;
            endcase
        end
    end

    // Lookup for the slot now at stage 2.
    assign v_idx = slot_d2[OIDX-1 -: VBITS];

    assign voice_lvl = key_gate[v_idx] ? voice_bank[v_idx] : '0;
    assign osc_lvl = lvl_bank[slot_d2[OIDX-1:0]];
    assign osc_pan = pan_bank[slot_d2[OIDX-1:0]];

endmodule

`default_nettype wire

// ==== src/phase_osc.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "synth_params.svh"

module phase_osc (
    input  logic                  sCLK_XVXENVS,
    input  logic                  reset,
    input  synth_pkg::slot_t      slot,
    input  logic                  cfg_we,
    input  synth_pkg::cfg_kind_e  cfg_kind,
    input  synth_pkg::slot_t      cfg_addr,
    input  logic [31:0]           cfg_data,
    output synth_pkg::sample_t    sine_out
);

    localparam int LUT_BITS = `SYN_LUT_BITS;
    localparam int LUT_SIZE = 1 << LUT_BITS;
    localparam int QBITS = LUT_BITS - 2;
    localparam int QSIZE = 1 << QBITS;
    localparam int OIDX = synth_pkg::OIDX_BITS;

    // Quarter wave including the peak entry.
    typedef synth_pkg::sample_t qtab_t [0:QSIZE];

    function automatic qtab_t build_qtab();
        qtab_t tab;
        real ang;
        for (int k = 0; k <= QSIZE; k++) begin
            ang = 2.0 * 3.14159265358979 * k / LUT_SIZE;
            tab[k] = synth_pkg::sample_t'($rtoi(32767.0 * $sin(ang) + 0.5));
        end
        return tab;
    endfunction

    localparam qtab_t QTAB = build_qtab();

    synth_pkg::phase_t phase_mem [synth_pkg::NUM_OSC];
    synth_pkg::phase_t inc_mem [synth_pkg::NUM_OSC];

    synth_pkg::phase_t phase_rd;
    synth_pkg::phase_t inc_rd;
    logic [OIDX-1:0]   wb_idx;
    logic              wb_ok;

    logic [LUT_BITS-1:0] lut_idx;
    logic [QBITS:0]      q_idx;
    synth_pkg::sample_t  q_val;

    logic cfg_inc;

    assign cfg_inc = cfg_we && (cfg_kind == synth_pkg::CFG_INC)
                     && (cfg_addr < synth_pkg::slot_t'(synth_pkg::NUM_OSC));

    // Stage 0 read of the phase and increment for this slot.
    always_ff @(posedge sCLK_XVXENVS) begin
        phase_rd <= phase_mem[slot[OIDX-1:0]];
        inc_rd   <= inc_mem[slot[OIDX-1:0]];
        wb_idx   <= slot[OIDX-1:0];
    end

    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            wb_ok <= 1'b0;
        end else begin
            wb_ok <= (slot < synth_pkg::slot_t'(synth_pkg::NUM_OSC));
        end
    end

    // Stage 1 write back; a new increment restarts the phase.
    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            for (int i = 0; i < synth_pkg::NUM_OSC; i++) begin
                phase_mem[i] <= '0;
                inc_mem[i]   <= '0;
            end
        end else begin
            if (wb_ok) begin
                phase_mem[wb_idx] <= phase_rd + inc_rd;
            end
            if (cfg_inc) begin
                inc_mem[cfg_addr[OIDX-1:0]]   <= cfg_data;
                phase_mem[cfg_addr[OIDX-1:0]] <= '0;
            end
        end
    end

    // Quadrant folding of the quarter table.
    assign lut_idx = phase_rd[31 -: LUT_BITS];
    assign q_idx = lut_idx[LUT_BITS-2] ?
                   ((QBITS + 1)'(QSIZE) - {1'b0, lut_idx[QBITS-1:0]}) :
                   {1'b0, lut_idx[QBITS-1:0]};
    assign q_val = QTAB[q_idx];

    always_ff @(posedge sCLK_XVXENVS) begin
        sine_out <= lut_idx[LUT_BITS-1] ? -q_val : q_val;
    end

endmodule

`default_nettype wire

// ==== src/slot_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "synth_params.svh"

module slot_sequencer (
    input  logic              sCLK_XVXENVS,
    input  logic              reset,
    output synth_pkg::slot_t  slot,
    output synth_pkg::slot_t  slot_d2,
    output logic              osc_stb,
    output logic              voice_end,
    output logic              frame_end
);

    localparam synth_pkg::slot_t LAST_SLOT = synth_pkg::slot_t'(`SYN_FRAME - 1);
    localparam synth_pkg::slot_t FIRST_PAD = synth_pkg::slot_t'(synth_pkg::NUM_OSC);
    localparam logic [synth_pkg::OSC_BITS-1:0] LAST_OSC =
        synth_pkg::OSC_BITS'(`SYN_V_OSC - 1);

    synth_pkg::slot_t slot_d1;

    // Slot counter, one oscillator slot per cycle.
    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            slot <= '0;
        end else if (slot == LAST_SLOT) begin
            slot <= '0;
        end else begin
            slot <= slot + 1'b1;
        end
    end

    // Delayed indices start on the last pad slot, as if a frame had just ended.
    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            slot_d1 <= LAST_SLOT;
            slot_d2 <= LAST_SLOT;
        end else begin
            slot_d1 <= slot;
            slot_d2 <= slot_d1;
        end
    end

    // Stage 2 carries a real oscillator.
    assign osc_stb = (slot_d2 < FIRST_PAD);

    // Voice boundary after its last oscillator, frame boundary one slot later.
    always_ff @(posedge sCLK_XVXENVS) begin
        if (reset) begin
            voice_end <= 1'b0;
            frame_end <= 1'b0;
        end else begin
            voice_end <= osc_stb && (slot_d2[synth_pkg::OSC_BITS-1:0] == LAST_OSC);
            frame_end <= (slot_d2 == FIRST_PAD);
        end
    end

endmodule

`default_nettype wire

// ==== src/synth_pkg.sv ====
`default_nettype none

`include "synth_params.svh"

package synth_pkg;

    localparam int NUM_OSC = `SYN_VOICES * `SYN_V_OSC;
    localparam int SLOT_BITS = $clog2(`SYN_FRAME);
    localparam int OSC_BITS = $clog2(`SYN_V_OSC);
    localparam int VOICE_BITS = $clog2(`SYN_VOICES);

    // Oscillator index part of a slot, voice in the upper bits.
    localparam int OIDX_BITS = OSC_BITS + VOICE_BITS;

    typedef logic signed [16:0] sample_t;
    typedef logic signed [7:0] level_t;
    typedef logic [6:0] pan_t;
    typedef logic signed [63:0] acc_t;
    typedef logic [31:0] phase_t;
    typedef logic [SLOT_BITS-1:0] slot_t;

    typedef enum logic [1:0] {
        CFG_INC       = 2'd0,
        CFG_OSC_LVL   = 2'd1,
        CFG_PAN       = 2'd2,
        CFG_VOICE_LVL = 2'd3
    } cfg_kind_e;

endpackage

`default_nettype wire

// ==== src/synth_params.svh ====
`ifndef SYNTH_PARAMS_SVH
`define SYNTH_PARAMS_SVH

// Voice and oscillator counts.
`define SYN_VOICES 4
`define SYN_V_OSC 4

// Width of the left and right output samples.
`define SYN_AUD_BITS 24

// Idle slots at the end of each frame.
`define SYN_PAD 4

// Sine table index width, 1024 entries over a full period.
`define SYN_LUT_BITS 10

// Final scaling of the master volume product.
`define SYN_OUT_SHIFT (54 - `SYN_AUD_BITS)

// One slot per oscillator plus the idle slots.
`define SYN_FRAME ((`SYN_VOICES * `SYN_V_OSC) + `SYN_PAD)

`endif
